/* Makefile */
# Verilator build and run for the timer peripheral subsystem

SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_periph_soc
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q -- '>>> PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_periph_soc.sv */
`timescale 1ns/1ns

module tb_periph_soc;

    import soc_bus_pkg::*;
    import timer_pkg::*;

    localparam int       NUM_TIMERS  = 4;
    localparam int       CLK_HALF    = 4;
    localparam int       RD_TIMEOUT  = 10;
    localparam int       IRQ_TIMEOUT = 100;
    localparam int       POLL_LIMIT  = 40;
    localparam int       OOR_SLOT    = 5;
    localparam reg_off_t UNUSED_OFF  = 2'd3;

    logic                  clk;
    logic                  rst_n_i;
    bus_req_t              req_i;
    data_t                 rdata_o;
    logic                  rvalid_o;
    logic [NUM_TIMERS-1:0] irq_o;

    int errors;
    int checks;

    // expected register contents per timer
    data_t exp_ctrl    [NUM_TIMERS];
    data_t exp_value   [NUM_TIMERS];
    data_t exp_compare [NUM_TIMERS];

    periph_soc #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) UUT (
        .clk        ( clk        ),
        .rst_n_i    ( rst_n_i    ),
        .req_i      ( req_i      ),
        .rdata_o    ( rdata_o    ),
        .rvalid_o   ( rvalid_o   ),
        .irq_o      ( irq_o      )
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic addr_t reg_addr(input int slot, input reg_off_t off);
        return (addr_t'(slot) << SLOT_LSB) | (addr_t'(off) << OFF_LSB);
    endfunction

    function automatic data_t bit_mask(input int pos);
        return data_t'(1) << pos;
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    // one-cycle write strobe, launched on the falling edge
    task automatic bus_write(input int slot, input reg_off_t off, input data_t data);
        @(negedge clk);
        req_i = '{req: 1'b1, we: 1'b1, addr: reg_addr(slot, off), wdata: data};
        @(negedge clk);
        req_i = '0;
    endtask

    task automatic bus_read(input int slot, input reg_off_t off, output data_t data);
        int waited;
        @(negedge clk);
        req_i = '{req: 1'b1, we: 1'b0, addr: reg_addr(slot, off), wdata: '0};
        @(negedge clk);
        req_i = '0;
        waited = 0;
        while (rvalid_o !== 1'b1 && waited < RD_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (rvalid_o === 1'b1) else begin
            errors++;
            $display("read of slot %0d offset %0d got no rvalid_o within %0d cycles at %0t ns",
                     slot, off, RD_TIMEOUT, $time);
        end
        if (rvalid_o === 1'b1) begin
            data = rdata_o;
            // valid must be a single pulse
            @(negedge clk);
            checks++;
            assert (rvalid_o === 1'b0) else begin
                errors++;
                $display("rvalid_o stayed high for more than one cycle at %0t ns", $time);
            end
        end else begin
            data = 'x;
        end
    endtask

    task automatic check_read(input int slot, input reg_off_t off, input data_t exp);
        data_t word;
        bus_read(slot, off, word);
        check_value($sformatf("rdata_o slot %0d off %0d", slot, off), word, exp);
    endtask

    task automatic wait_irq(input int idx, input logic level);
        int waited;
        waited = 0;
        while (irq_o[idx] !== level && waited < IRQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (irq_o[idx] === level) else begin
            errors++;
            $display("irq_o[%0d] did not reach %b within %0d cycles at %0t ns",
                     idx, level, IRQ_TIMEOUT, $time);
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        check_value("irq_o", data_t'(irq_o), '0);
        check_value("rvalid_o", data_t'(rvalid_o), '0);
        for (int s = 0; s < NUM_TIMERS; s++) begin
            for (int off = 0; off < 4; off++) begin
                check_read(s, reg_off_t'(off), '0);
            end
        end
    endtask

    task automatic test_register_roundtrip();
        for (int s = 0; s < NUM_TIMERS; s++) begin
            exp_value[s]   = $urandom();
            exp_compare[s] = $urandom();
            // low four bits zero, so the timer stays off
            exp_ctrl[s]    = $urandom() & 32'hFFFF_FFF0;
            bus_write(s, TMR_VALUE, exp_value[s]);
            bus_write(s, TMR_COMPARE, exp_compare[s]);
            bus_write(s, TMR_CTRL, exp_ctrl[s]);
        end
        for (int s = 0; s < NUM_TIMERS; s++) begin
            check_read(s, TMR_VALUE, exp_value[s]);
            check_read(s, TMR_COMPARE, exp_compare[s]);
            check_read(s, TMR_CTRL, exp_ctrl[s]);
        end
    endtask

    task automatic test_unmapped_access();
        for (int off = 0; off < 4; off++) begin
            bus_write(OOR_SLOT, reg_off_t'(off), $urandom());
        end
        for (int s = 0; s < NUM_TIMERS; s++) begin
            bus_write(s, UNUSED_OFF, $urandom());
        end
        for (int off = 0; off < 4; off++) begin
            check_read(OOR_SLOT, reg_off_t'(off), '0);
        end
        for (int s = 0; s < NUM_TIMERS; s++) begin
            check_read(s, UNUSED_OFF, '0);
            check_read(s, TMR_CTRL, exp_ctrl[s]);
            check_read(s, TMR_VALUE, exp_value[s]);
            check_read(s, TMR_COMPARE, exp_compare[s]);
        end
    endtask

    task automatic test_periodic_irq();
        // long period keeps the clear well away from the next match
        bus_write(1, TMR_COMPARE, 32'd40);
        bus_write(1, TMR_VALUE, '0);
        bus_write(1, TMR_CTRL, bit_mask(CTRL_EN) | bit_mask(CTRL_IE));
        wait_irq(1, 1'b1);
        check_value("irq_o", data_t'(irq_o), bit_mask(1));
        bus_write(1, TMR_CTRL, bit_mask(CTRL_EN) | bit_mask(CTRL_IE) | bit_mask(CTRL_PEND));
        wait_irq(1, 1'b0);
        // still running, so it comes back
        wait_irq(1, 1'b1);
        check_value("irq_o", data_t'(irq_o), bit_mask(1));
        bus_write(1, TMR_CTRL, bit_mask(CTRL_PEND));
        wait_irq(1, 1'b0);
    endtask

    task automatic test_oneshot();
        bus_write(2, TMR_COMPARE, 32'd10);
        bus_write(2, TMR_VALUE, '0);
        bus_write(2, TMR_CTRL, bit_mask(CTRL_EN) | bit_mask(CTRL_IE) | bit_mask(CTRL_ONESHOT));
        wait_irq(2, 1'b1);
        check_value("irq_o", data_t'(irq_o), bit_mask(2));
        check_read(2, TMR_CTRL, bit_mask(CTRL_IE) | bit_mask(CTRL_PEND) | bit_mask(CTRL_ONESHOT));
        // count wrapped to zero and stays there
        check_read(2, TMR_VALUE, '0);
        check_read(2, TMR_VALUE, '0);
        bus_write(2, TMR_CTRL, bit_mask(CTRL_PEND));
        wait_irq(2, 1'b0);
    endtask

    task automatic test_masked_irq();
        data_t word;
        logic  seen;
        int    polls;
        bus_write(3, TMR_COMPARE, 32'd8);
        bus_write(3, TMR_VALUE, '0);
        bus_write(3, TMR_CTRL, bit_mask(CTRL_EN));
        seen  = 1'b0;
        polls = 0;
        word  = '0;
        while (!seen && polls < POLL_LIMIT) begin
            bus_read(3, TMR_CTRL, word);
            seen = word[CTRL_PEND];
            check_value("irq_o", data_t'(irq_o), '0);
            polls++;
        end
        checks++;
        assert (seen) else begin
            errors++;
            $display("pending never set in slot 3 CTRL after %0d reads", POLL_LIMIT);
        end
        check_value("slot 3 CTRL", word, bit_mask(CTRL_EN) | bit_mask(CTRL_PEND));
        repeat (2) @(negedge clk);
        check_value("irq_o", data_t'(irq_o), '0);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        errors  = 0;
        checks  = 0;
        rst_n_i = 1'b0;
        req_i   = '0;
        void'($urandom(83));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        test_reset_state();
        test_register_roundtrip();
        test_unmapped_access();
        test_periodic_irq();
        test_oneshot();
        test_masked_irq();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src/bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                  clk,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::bus_req_t slot_req_o [NUM_TIMERS],
    output logic                  rd_req_o,
    output logic                  rd_hit_o,
    output soc_bus_pkg::slot_t    rd_slot_o
);

    import soc_bus_pkg::*;

    slot_t                 slot;
    logic                  hit;
    logic [NUM_TIMERS-1:0] strobes;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    assign slot = req_i.addr[SLOT_LSB +: $bits(slot_t)];

    // slots at or above NUM_TIMERS are empty
    assign hit = (int'(slot) < NUM_TIMERS);

    // ------------------------------------------------------------------------
    // per-slot request fan-out
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_slot
        assign strobes[i] = req_i.req & hit & (slot == slot_t'(i));

        // only the strobe differs between slots
        assign slot_req_o[i] = '{
            req:   strobes[i],
            we:    req_i.we,
            addr:  req_i.addr,
            wdata: req_i.wdata
        };
    end

    // ------------------------------------------------------------------------
    // read side info for the collector
    // ------------------------------------------------------------------------
    // a missing read still gets a valid pulse with zero data
    assign rd_req_o  = req_i.req & ~req_i.we;
    assign rd_hit_o  = hit;
    assign rd_slot_o = slot;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // timers never see two strobes at once
    a_one_slot : assert property (
        @(posedge clk) $onehot0(strobes)
    ) else $error("bus_decoder: more than one slot strobe active");

endmodule

/* src/periph_soc.sv */
`timescale 1ns/1ns

module periph_soc #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::data_t    rdata_o,
    output logic                  rvalid_o,
    output logic [NUM_TIMERS-1:0] irq_o
);

    import soc_bus_pkg::*;

    bus_req_t              slot_req [NUM_TIMERS];
    data_t                 slot_rdata [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] slot_irq;
    logic                  rd_req;
    logic                  rd_hit;
    slot_t                 rd_slot;

    // ------------------------------------------------------------------------
    // address decoder
    // ------------------------------------------------------------------------
    bus_decoder #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) u_bus_decoder (
        .clk        ( clk        ),
        .req_i      ( req_i      ),
        .slot_req_o ( slot_req   ),
        .rd_req_o   ( rd_req     ),
        .rd_hit_o   ( rd_hit     ),
        .rd_slot_o  ( rd_slot    )
    );

    // ------------------------------------------------------------------------
    // timer bank, one per slot
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        periph_timer u_timer (
            .clk     ( clk           ),
            .rst_n_i ( rst_n_i       ),
            .req_i   ( slot_req[i]   ),
            .rdata_o ( slot_rdata[i] ),
            .irq_o   ( slot_irq[i]   )
        );
    end

    // read data return and irq vector
    read_collector #(
        .NUM_TIMERS   ( NUM_TIMERS )
    ) u_read_collector (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .rd_req_i     ( rd_req     ),
        .rd_hit_i     ( rd_hit     ),
        .rd_slot_i    ( rd_slot    ),
        .slot_rdata_i ( slot_rdata ),
        .slot_irq_i   ( slot_irq   ),
        .rdata_o      ( rdata_o    ),
        .rvalid_o     ( rvalid_o   ),
        .irq_o        ( irq_o      )
    );

endmodule

/* src/periph_timer.sv */
`timescale 1ns/1ns

module periph_timer (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::data_t    rdata_o,
    output logic                  irq_o
);

    import soc_bus_pkg::*;
    import timer_pkg::*;

    reg_off_t off;
    logic     wr_en;
    logic     ctrl_wr;
    logic     match;
    data_t    ctrl_q;
    data_t    value_q;
    data_t    compare_q;

    // ------------------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------------------
    assign off     = req_i.addr[OFF_LSB +: $bits(reg_off_t)];
    assign wr_en   = req_i.req & req_i.we;
    assign ctrl_wr = wr_en && (off == TMR_CTRL);

    // count reached compare while running
    assign match = ctrl_q[CTRL_EN] && (value_q == compare_q);

    // ------------------------------------------------------------------------
    // control register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= req_i.wdata;
                // pending is write one to clear
                ctrl_q[CTRL_PEND] <= ctrl_q[CTRL_PEND] & ~req_i.wdata[CTRL_PEND];
            end
            // match wins over a clear in the same cycle
            if (match) begin
                ctrl_q[CTRL_PEND] <= 1'b1;
                if (ctrl_q[CTRL_ONESHOT]) begin
                    ctrl_q[CTRL_EN] <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // counter and compare
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            value_q <= '0;
        end else if (wr_en && (off == TMR_VALUE)) begin
            value_q <= req_i.wdata;
        end else if (match) begin
            value_q <= '0;
        end else if (ctrl_q[CTRL_EN]) begin
            value_q <= value_q + data_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            compare_q <= '0;
        end else if (wr_en && (off == TMR_COMPARE)) begin
            compare_q <= req_i.wdata;
        end
    end

    // ------------------------------------------------------------------------
    // read word and interrupt
    // ------------------------------------------------------------------------
    always_comb begin
        case (off)
            TMR_CTRL:    rdata_o = ctrl_q;
            TMR_VALUE:   rdata_o = value_q;
            TMR_COMPARE: rdata_o = compare_q;
            default:     rdata_o = '0;
        endcase
    end

    assign irq_o = ctrl_q[CTRL_PEND] & ctrl_q[CTRL_IE];

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // pending only comes from a match of a running counter
    a_pend_needs_en : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(ctrl_q[CTRL_PEND]) |-> ($past(ctrl_q[CTRL_EN]) || $past(ctrl_wr))
    ) else $error("periph_timer: pending set while disabled");

endmodule

/* src/read_collector.sv */
`timescale 1ns/1ns

module read_collector #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  rd_req_i,
    input  logic                  rd_hit_i,
    input  soc_bus_pkg::slot_t    rd_slot_i,
    input  soc_bus_pkg::data_t    slot_rdata_i [NUM_TIMERS],
    input  logic [NUM_TIMERS-1:0] slot_irq_i,
    output soc_bus_pkg::data_t    rdata_o,
    output logic                  rvalid_o,
    output logic [NUM_TIMERS-1:0] irq_o
);

    import soc_bus_pkg::*;

    data_t sel_rdata;

    // ------------------------------------------------------------------------
    // read data select
    // ------------------------------------------------------------------------
    // decoder already flagged misses, so zero them here
    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (rd_slot_i == slot_t'(i)) begin
                sel_rdata = slot_rdata_i[i];
            end
        end
        if (!rd_hit_i) begin
            sel_rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_i) begin
            rdata_o <= sel_rdata;
        end
    end

    // ------------------------------------------------------------------------
    // valid strobe and interrupt vector
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_o <= 1'b0;
            irq_o    <= '0;
        end else begin
            rvalid_o <= rd_req_i;
            irq_o    <= slot_irq_i;
        end
    end

    // one valid pulse per read, never without a read
    a_valid_after_req : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        rvalid_o |-> $past(rd_req_i)
    ) else $error("read_collector: rvalid without a read request");

endmodule

/* src/soc_bus_pkg.sv */
package soc_bus_pkg;

    // ------------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SLOT_W = 4;
    localparam int OFF_W  = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // slot index, address bits 11..8
    typedef logic [SLOT_W-1:0] slot_t;

    // word offset inside a slot, address bits 3..2
    typedef logic [OFF_W-1:0] reg_off_t;

    // ------------------------------------------------------------------------
    // address field positions
    // ------------------------------------------------------------------------
    localparam int SLOT_LSB = 8;
    localparam int OFF_LSB  = 2;

    // single-cycle request from the master
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

endpackage

/* src/timer_pkg.sv */
package timer_pkg;

    // ------------------------------------------------------------------------
    // register map, word offsets inside a timer slot
    // ------------------------------------------------------------------------
    // offset 3 is unused: reads zero, writes dropped
    localparam soc_bus_pkg::reg_off_t TMR_CTRL    = 2'd0;
    localparam soc_bus_pkg::reg_off_t TMR_VALUE   = 2'd1;
    localparam soc_bus_pkg::reg_off_t TMR_COMPARE = 2'd2;

    // ------------------------------------------------------------------------
    // CTRL bit positions
    // ------------------------------------------------------------------------
    // counter runs while set
    localparam int CTRL_EN      = 0;

    // interrupt enable, masks the irq line only
    localparam int CTRL_IE      = 1;

    // set on match, write one to clear
    localparam int CTRL_PEND    = 2;

    // stop after the first match
    localparam int CTRL_ONESHOT = 3;

    // bits above ONESHOT are plain storage

endpackage

/* verilog.f */
src/soc_bus_pkg.sv
src/timer_pkg.sv
src/bus_decoder.sv
src/periph_timer.sv
src/read_collector.sv
src/periph_soc.sv
bench/tb_periph_soc.sv
